/* common/cpu_fe_pkg.sv */
// Front-end definitions shared by fetch, queue and decode; QUEUE_DEPTH must be a power of two, 4 or more
package cpu_fe_pkg;

   // Widths
   localparam int INSN_W    = 16;
   localparam int ADDR_W    = 32;
   localparam int PCB_WIDTH = 6;

   // Instruction queue
   localparam int QUEUE_DEPTH = 4;
   localparam int QPTR_W      = $clog2(QUEUE_DEPTH);

   // First fetch address after reset
   localparam logic [ADDR_W-1:0] RESET_PC = '0;

   // Pipeline control bits
   // [5] write reg A, [4] write reg B, [3] read memory,
   // [2] write memory, [1] change of flow, [0] operand used
   localparam logic [PCB_WIDTH-1:0] CTL_NONE    = 6'b000000;
   localparam logic [PCB_WIDTH-1:0] CTL_ALU     = 6'b100000;
   localparam logic [PCB_WIDTH-1:0] CTL_ALU_IMM = 6'b100001;
   localparam logic [PCB_WIDTH-1:0] CTL_LOAD    = 6'b101000;
   localparam logic [PCB_WIDTH-1:0] CTL_STORE   = 6'b000100;
   localparam logic [PCB_WIDTH-1:0] CTL_FLOW    = 6'b000010;
   localparam logic [PCB_WIDTH-1:0] CTL_POP     = 6'b110000;

   // Decoded operations
   typedef enum logic [6:0] {
      // Form 1, exact high byte
      OP_NOP,
      OP_LDI_L,
      OP_MOV,
      OP_JSRA,
      OP_RET,
      OP_ADD_L,
      OP_PUSH,
      OP_POP,
      OP_LDA_L,
      OP_STA_L,
      OP_LD_L,
      OP_ST_L,
      OP_LDO_L,
      OP_STO_L,
      OP_CMP,
      OP_JSR,
      OP_JMPA,
      OP_LDI_B,
      OP_LD_B,
      OP_LDA_B,
      OP_ST_B,
      OP_STA_B,
      OP_LDI_S,
      OP_LD_S,
      OP_LDA_S,
      OP_ST_S,
      OP_STA_S,
      OP_JMP,
      OP_AND,
      OP_LSHR,
      OP_ASHL,
      OP_SUB_L,
      OP_NEG,
      OP_OR,
      OP_NOT,
      OP_ASHR,
      OP_XOR,
      OP_MUL_L,
      OP_SWI,
      OP_DIV_L,
      OP_UDIV_L,
      OP_MOD_L,
      OP_UMOD_L,
      OP_BRK,
      OP_LDO_B,
      OP_STO_B,
      OP_LDO_S,
      OP_STO_S,
      // Form 2
      OP_INC,
      OP_DEC,
      OP_GSR,
      OP_SSR,
      // Form 3 branches
      OP_BEQ,
      OP_BNE,
      OP_BLT,
      OP_BGT,
      OP_BLTU,
      OP_BGTU,
      OP_BGE,
      OP_BLE,
      OP_BGEU,
      OP_BLEU,
      OP_BAD
   } op_t;

   // One instruction as fetched
   typedef struct packed {
      logic [ADDR_W-1:0] pc;
      logic [INSN_W-1:0] opcode;
      logic [31:0]       operand;
   } fetch_entry_t;

   // High bytes followed by a 32-bit immediate, high halfword first
   function automatic logic insn_has_operand(input logic [7:0] opcode_hi);
      case (opcode_hi)
         8'h01, 8'h03, 8'h08, 8'h09, 8'h1A:
            return 1'b1;
         default:
            return 1'b0;
      endcase
   endfunction

endpackage

/* fetch/insn_fetch.sv */
// Memory must answer each request exactly one cycle later and never refuses one; requests follow room_i
module insn_fetch (
   input  logic                          clk_i,
   input  logic                          arst_n_i,
   input  logic                          flush_i,
   input  logic [cpu_fe_pkg::ADDR_W-1:0] flush_pc_i,
   input  logic [cpu_fe_pkg::INSN_W-1:0] imem_data_i,
   input  logic                          room_i,
   output logic                          imem_req_o,
   output logic [cpu_fe_pkg::ADDR_W-1:0] imem_addr_o,
   output logic                          push_o,
   output cpu_fe_pkg::fetch_entry_t      entry_o
);
   import cpu_fe_pkg::*;

   logic              run_q;
   logic [ADDR_W-1:0] pc_q;
   logic              inflight_q;
   logic [1:0]        hw_cnt_q;
   logic              push_q;
   fetch_entry_t      entry_q;
   logic              take_data;

   // No request in the first cycle after reset release
   assign imem_req_o  = run_q & room_i;
   assign imem_addr_o = pc_q;

   // Data returning in the flush cycle belongs to the old stream
   assign take_data = inflight_q & ~flush_i;

   assign push_o  = push_q;
   assign entry_o = entry_q;

   // Request PC, in-flight marker and halfword sequencing
   always_ff @(posedge clk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         run_q      <= 1'b0;
         pc_q       <= RESET_PC;
         inflight_q <= 1'b0;
         hw_cnt_q   <= 2'd0;
         push_q     <= 1'b0;
      end
      else
      begin
         run_q  <= 1'b1;
         push_q <= 1'b0;
         if (flush_i)
         begin
            pc_q       <= flush_pc_i;
            inflight_q <= 1'b0;
            hw_cnt_q   <= 2'd0;
         end
         else
         begin
            inflight_q <= imem_req_o;
            if (imem_req_o)
               pc_q <= pc_q + ADDR_W'(2);
            if (take_data)
            begin
               case (hw_cnt_q)
                  2'd0:
                  begin
                     if (insn_has_operand(imem_data_i[INSN_W-1:INSN_W-8]))
                        hw_cnt_q <= 2'd1;
                     else
                        push_q <= 1'b1;
                  end
                  2'd1:
                     hw_cnt_q <= 2'd2;
                  default:
                  begin
                     hw_cnt_q <= 2'd0;
                     push_q   <= 1'b1;
                  end
               endcase
            end
         end
      end
   end

   // Assembly register; pc_q has already moved one halfword past the returning data
   always_ff @(posedge clk_i)
   begin
      if (take_data)
      begin
         case (hw_cnt_q)
            2'd0:
            begin
               entry_q.pc      <= pc_q - ADDR_W'(2);
               entry_q.opcode  <= imem_data_i;
               entry_q.operand <= '0;
            end
            2'd1:
               entry_q.operand[31:16] <= imem_data_i;
            default:
               entry_q.operand[15:0] <= imem_data_i;
         endcase
      end
   end

endmodule

/* rtl/insn_queue.sv */
// Pushing while room_o is low overflows the queue; the two-slot margin assumes the fetch pipeline
module insn_queue (
   input  logic                     clk_i,
   input  logic                     arst_n_i,
   input  logic                     flush_i,
   input  logic                     push_i,
   input  cpu_fe_pkg::fetch_entry_t entry_i,
   input  logic                     pop_i,
   output logic                     room_o,
   output logic                     not_empty_o,
   output cpu_fe_pkg::fetch_entry_t head_o
);
   import cpu_fe_pkg::*;

   fetch_entry_t      mem_q [QUEUE_DEPTH];
   logic [QPTR_W-1:0] wr_ptr_q;
   logic [QPTR_W-1:0] rd_ptr_q;
   logic [QPTR_W:0]   count_q;
   logic [QPTR_W:0]   fill;
   logic              do_pop;

   // Stored entries plus the one arriving now
   assign fill   = count_q + (QPTR_W+1)'(push_i);
   assign room_o = (fill <= (QPTR_W+1)'(QUEUE_DEPTH - 2));

   // Hidden in the flush cycle so decode takes nothing that is being dropped
   assign not_empty_o = (count_q != '0) & ~flush_i;
   assign head_o      = mem_q[rd_ptr_q];
   assign do_pop      = pop_i & not_empty_o;

   always_ff @(posedge clk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end
      else if (flush_i)
      begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end
      else
      begin
         if (push_i)
            wr_ptr_q <= wr_ptr_q + QPTR_W'(1);
         if (do_pop)
            rd_ptr_q <= rd_ptr_q + QPTR_W'(1);
         case ({push_i, do_pop})
            2'b10:   count_q <= count_q + (QPTR_W+1)'(1);
            2'b01:   count_q <= count_q - (QPTR_W+1)'(1);
            default: count_q <= count_q;
         endcase
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (push_i)
         mem_q[wr_ptr_q] <= entry_i;
   end

endmodule

/* decode/microcode_rom.sv */
// Form-1 control bits only; INC, DEC and branch control is chosen in decode
module microcode_rom (
   input  logic [7:0]                       opcode_hi_i,
   output logic [cpu_fe_pkg::PCB_WIDTH-1:0] control_o
);
   import cpu_fe_pkg::*;

   always_comb
   begin
      case (opcode_hi_i)
         // Register-writing ALU and move ops
         8'h02, 8'h05, 8'h1B, 8'h20,
         8'h26, 8'h27, 8'h28, 8'h29, 8'h2A, 8'h2B, 8'h2C, 8'h2D, 8'h2E, 8'h2F,
         8'h31, 8'h32, 8'h33, 8'h34:
            control_o = CTL_ALU;
         // LDI_L carries its immediate
         8'h01:
            control_o = CTL_ALU_IMM;
         // Loads
         8'h08, 8'h0A, 8'h0C, 8'h1C, 8'h1D, 8'h21, 8'h22, 8'h36, 8'h38:
            control_o = CTL_LOAD;
         // Stores, PUSH included
         8'h06, 8'h09, 8'h0B, 8'h0D, 8'h1E, 8'h1F, 8'h23, 8'h24, 8'h37, 8'h39:
            control_o = CTL_STORE;
         // Jumps, calls, returns and SWI
         8'h03, 8'h04, 8'h19, 8'h1A, 8'h25, 8'h30:
            control_o = CTL_FLOW;
         8'h07:
            control_o = CTL_POP;
         // NOP, CMP, BRK and the unused codes
         default:
            control_o = CTL_NONE;
      endcase
   end

endmodule

/* decode/insn_decode.sv */
// Pops only when the queue is not empty and stall_i is low; outputs hold while stalled
module insn_decode (
   input  logic                             clk_i,
   input  logic                             arst_n_i,
   input  logic                             stall_i,
   input  logic                             not_empty_i,
   input  cpu_fe_pkg::fetch_entry_t         head_i,
   output logic                             pop_o,
   output logic                             valid_o,
   output cpu_fe_pkg::op_t                  op_o,
   output logic [cpu_fe_pkg::ADDR_W-1:0]    pc_o,
   output logic [31:0]                      operand_o,
   output logic [9:0]                       pcrel_offset_o,
   output logic [3:0]                       reg_a_idx_o,
   output logic [3:0]                       reg_b_idx_o,
   output logic [cpu_fe_pkg::PCB_WIDTH-1:0] control_o
);
   import cpu_fe_pkg::*;

   logic [7:0]           opc_hi;
   logic                 form1;
   logic                 is_incdec;
   logic                 is_branch;
   logic [PCB_WIDTH-1:0] rom_ctl;
   logic [PCB_WIDTH-1:0] ctl_next;
   logic [31:0]          operand_next;

   function automatic op_t decode_op(input logic [7:0] hi);
      casez (hi)
         8'h00: return OP_NOP;
         8'h01: return OP_LDI_L;
         8'h02: return OP_MOV;
         8'h03: return OP_JSRA;
         8'h04: return OP_RET;
         8'h05: return OP_ADD_L;
         8'h06: return OP_PUSH;
         8'h07: return OP_POP;
         8'h08: return OP_LDA_L;
         8'h09: return OP_STA_L;
         8'h0A: return OP_LD_L;
         8'h0B: return OP_ST_L;
         8'h0C: return OP_LDO_L;
         8'h0D: return OP_STO_L;
         8'h0E: return OP_CMP;
         8'h19: return OP_JSR;
         8'h1A: return OP_JMPA;
         8'h1B: return OP_LDI_B;
         8'h1C: return OP_LD_B;
         8'h1D: return OP_LDA_B;
         8'h1E: return OP_ST_B;
         8'h1F: return OP_STA_B;
         8'h20: return OP_LDI_S;
         8'h21: return OP_LD_S;
         8'h22: return OP_LDA_S;
         8'h23: return OP_ST_S;
         8'h24: return OP_STA_S;
         8'h25: return OP_JMP;
         8'h26: return OP_AND;
         8'h27: return OP_LSHR;
         8'h28: return OP_ASHL;
         8'h29: return OP_SUB_L;
         8'h2A: return OP_NEG;
         8'h2B: return OP_OR;
         8'h2C: return OP_NOT;
         8'h2D: return OP_ASHR;
         8'h2E: return OP_XOR;
         8'h2F: return OP_MUL_L;
         8'h30: return OP_SWI;
         8'h31: return OP_DIV_L;
         8'h32: return OP_UDIV_L;
         8'h33: return OP_MOD_L;
         8'h34: return OP_UMOD_L;
         8'h35: return OP_BRK;
         8'h36: return OP_LDO_B;
         8'h37: return OP_STO_B;
         8'h38: return OP_LDO_S;
         8'h39: return OP_STO_S;
         8'b1000????: return OP_INC;
         8'b1001????: return OP_DEC;
         8'b1010????: return OP_GSR;
         8'b1011????: return OP_SSR;
         8'b110000??: return OP_BEQ;
         8'b110001??: return OP_BNE;
         8'b110010??: return OP_BLT;
         8'b110011??: return OP_BGT;
         8'b110100??: return OP_BLTU;
         8'b110101??: return OP_BGTU;
         8'b110110??: return OP_BGE;
         8'b110111??: return OP_BLE;
         8'b111000??: return OP_BGEU;
         8'b111001??: return OP_BLEU;
         default:     return OP_BAD;
      endcase
   endfunction

   assign opc_hi    = head_i.opcode[INSN_W-1:INSN_W-8];
   assign form1     = ~head_i.opcode[INSN_W-1];
   assign is_incdec = (opc_hi[7:5] == 3'b100);
   // Form-3 conditions above 9 are undefined and carry no control bits
   assign is_branch = (opc_hi[7:6] == 2'b11) && (opc_hi[5:2] <= 4'd9);
   assign pop_o     = not_empty_i & ~stall_i;

   microcode_rom u_rom (
      .opcode_hi_i (opc_hi),
      .control_o   (rom_ctl)
   );

   always_comb
   begin
      if (form1)
         ctl_next = rom_ctl;
      else if (is_incdec)
         ctl_next = CTL_LOAD;
      else if (is_branch)
         ctl_next = CTL_FLOW;
      else
         ctl_next = CTL_NONE;
   end

   // Long forms pass the immediate, INC and DEC their low byte
   always_comb
   begin
      if (insn_has_operand(opc_hi))
         operand_next = head_i.operand;
      else if (is_incdec)
         operand_next = {24'b0, head_i.opcode[7:0]};
      else
         operand_next = '0;
   end

   always_ff @(posedge clk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         valid_o <= 1'b0;
         op_o    <= OP_NOP;
      end
      else if (!stall_i)
      begin
         valid_o <= not_empty_i;
         op_o    <= not_empty_i ? decode_op(opc_hi) : OP_NOP;
      end
   end

   // Payload toward execute
   always_ff @(posedge clk_i)
   begin
      if (pop_o)
      begin
         pc_o           <= head_i.pc;
         operand_o      <= operand_next;
         pcrel_offset_o <= head_i.opcode[9:0];
         reg_a_idx_o    <= form1 ? head_i.opcode[7:4] : head_i.opcode[11:8];
         reg_b_idx_o    <= head_i.opcode[3:0];
         control_o      <= ctl_next;
      end
   end

endmodule

/* rtl/cpu_frontend.sv */
// Flush PC comes from outside; flush_i must be a one-cycle pulse
module cpu_frontend (
   input  logic                             clk_i,
   input  logic                             arst_n_i,
   input  logic                             stall_i,
   input  logic                             flush_i,
   input  logic [cpu_fe_pkg::ADDR_W-1:0]    flush_pc_i,
   input  logic [cpu_fe_pkg::INSN_W-1:0]    imem_data_i,
   output logic                             imem_req_o,
   output logic [cpu_fe_pkg::ADDR_W-1:0]    imem_addr_o,
   output logic                             valid_o,
   output cpu_fe_pkg::op_t                  op_o,
   output logic [cpu_fe_pkg::ADDR_W-1:0]    pc_o,
   output logic [31:0]                      operand_o,
   output logic [9:0]                       pcrel_offset_o,
   output logic [3:0]                       reg_a_idx_o,
   output logic [3:0]                       reg_b_idx_o,
   output logic [cpu_fe_pkg::PCB_WIDTH-1:0] control_o
);
   import cpu_fe_pkg::*;

   logic         push;
   fetch_entry_t push_entry;
   logic         room;
   logic         not_empty;
   fetch_entry_t head;
   logic         pop;

   insn_fetch u_fetch (
      .clk_i       (clk_i),
      .arst_n_i    (arst_n_i),
      .flush_i     (flush_i),
      .flush_pc_i  (flush_pc_i),
      .imem_data_i (imem_data_i),
      .room_i      (room),
      .imem_req_o  (imem_req_o),
      .imem_addr_o (imem_addr_o),
      .push_o      (push),
      .entry_o     (push_entry)
   );

   insn_queue u_queue (
      .clk_i       (clk_i),
      .arst_n_i    (arst_n_i),
      .flush_i     (flush_i),
      .push_i      (push),
      .entry_i     (push_entry),
      .pop_i       (pop),
      .room_o      (room),
      .not_empty_o (not_empty),
      .head_o      (head)
   );

   insn_decode u_decode (
      .clk_i          (clk_i),
      .arst_n_i       (arst_n_i),
      .stall_i        (stall_i),
      .not_empty_i    (not_empty),
      .head_i         (head),
      .pop_o          (pop),
      .valid_o        (valid_o),
      .op_o           (op_o),
      .pc_o           (pc_o),
      .operand_o      (operand_o),
      .pcrel_offset_o (pcrel_offset_o),
      .reg_a_idx_o    (reg_a_idx_o),
      .reg_b_idx_o    (reg_b_idx_o),
      .control_o      (control_o)
   );

endmodule

/* test/tb_decode_ref.svh */
// Expected decode results from the instruction set rules; cpu_fe_pkg must be imported before inclusion
`ifndef TB_DECODE_REF_SVH
`define TB_DECODE_REF_SVH

// High bytes whose opcode is followed by a 32-bit immediate
function automatic logic ref_is_long(input logic [7:0] hi);
   return (hi == 8'h01) || (hi == 8'h03) || (hi == 8'h08) || (hi == 8'h09) || (hi == 8'h1A);
endfunction

// Form 1 codes 0x00-0x0E and 0x19-0x39 map in order onto the enumeration
function automatic op_t ref_op(input logic [INSN_W-1:0] opc);
   logic [7:0] hi;
   hi = opc[15:8];
   if (!hi[7])
   begin
      if (hi <= 8'h0E)
         return op_t'(7'(hi));
      if (hi >= 8'h19 && hi <= 8'h39)
         return op_t'(7'(int'(OP_JSR) + int'(hi) - 'h19));
      return OP_BAD;
   end
   // Form 2 picks INC, DEC, GSR or SSR by bits 13:12
   if (!hi[6])
      return op_t'(7'(int'(OP_INC) + int'(hi[5:4])));
   // Form 3 branch condition in bits 13:10
   if (hi[5:2] <= 4'd9)
      return op_t'(7'(int'(OP_BEQ) + int'(hi[5:2])));
   return OP_BAD;
endfunction

function automatic logic [31:0] ref_operand(input fetch_entry_t rec);
   if (ref_is_long(rec.opcode[15:8]))
      return rec.operand;
   if (rec.opcode[15:13] == 3'b100)
      return {24'b0, rec.opcode[7:0]};
   return '0;
endfunction

function automatic logic [PCB_WIDTH-1:0] ref_control(input logic [INSN_W-1:0] opc);
   case (ref_op(opc))
      OP_MOV, OP_ADD_L, OP_LDI_L, OP_LDI_B, OP_LDI_S, OP_AND, OP_LSHR, OP_ASHL,
      OP_SUB_L, OP_NEG, OP_OR, OP_NOT, OP_ASHR, OP_XOR, OP_MUL_L,
      OP_DIV_L, OP_UDIV_L, OP_MOD_L, OP_UMOD_L:
         return {5'b10000, ref_is_long(opc[15:8])};
      OP_LDA_L, OP_LD_L, OP_LDO_L, OP_LD_B, OP_LDA_B, OP_LD_S, OP_LDA_S,
      OP_LDO_B, OP_LDO_S, OP_INC, OP_DEC:
         return 6'b101000;
      OP_PUSH, OP_STA_L, OP_ST_L, OP_STO_L, OP_ST_B, OP_STA_B, OP_ST_S, OP_STA_S,
      OP_STO_B, OP_STO_S:
         return 6'b000100;
      OP_JSRA, OP_RET, OP_JSR, OP_JMPA, OP_JMP, OP_SWI,
      OP_BEQ, OP_BNE, OP_BLT, OP_BGT, OP_BLTU, OP_BGTU, OP_BGE, OP_BLE, OP_BGEU, OP_BLEU:
         return 6'b000010;
      OP_POP:
         return 6'b110000;
      default:
         return 6'b000000;
   endcase
endfunction

function automatic logic [3:0] ref_reg_a(input logic [INSN_W-1:0] opc);
   return opc[15] ? opc[11:8] : opc[7:4];
endfunction

function automatic logic [3:0] ref_reg_b(input logic [INSN_W-1:0] opc);
   return opc[3:0];
endfunction

function automatic logic [9:0] ref_offset(input logic [INSN_W-1:0] opc);
   return opc[9:0];
endfunction

`endif

/* test/tb_cpu_frontend.sv */
// Memory model answers one cycle after each request from an 8 KB image that wraps around
module tb_cpu_frontend;
   import cpu_fe_pkg::*;

   `include "tb_decode_ref.svh"

   localparam int MEM_HW      = 4096;
   localparam int DRAIN_LIMIT = 3000;
   localparam int REQ_LIMIT   = 20;
   localparam int IDLE_LIMIT  = 40;
   localparam int KIND_MIX    = 0;
   localparam int KIND_INCDEC = 1;
   localparam int KIND_BRANCH = 2;

   logic                 clk_i;
   logic                 arst_n_i;
   logic                 stall_i;
   logic                 flush_i;
   logic [ADDR_W-1:0]    flush_pc_i;
   logic [INSN_W-1:0]    imem_data_i;
   logic                 imem_req_o;
   logic [ADDR_W-1:0]    imem_addr_o;
   logic                 valid_o;
   op_t                  op_o;
   logic [ADDR_W-1:0]    pc_o;
   logic [31:0]          operand_o;
   logic [9:0]           pcrel_offset_o;
   logic [3:0]           reg_a_idx_o;
   logic [3:0]           reg_b_idx_o;
   logic [PCB_WIDTH-1:0] control_o;

   logic [INSN_W-1:0] prog [MEM_HW];
   fetch_entry_t      exp_q [$];
   logic              req_seen;
   logic [ADDR_W-1:0] addr_seen;
   logic              fresh;
   logic [ADDR_W-1:0] first_pc;
   int                checks;
   int                errors;
   int                tests_done;

   cpu_frontend u_dut (
      .clk_i          (clk_i),
      .arst_n_i       (arst_n_i),
      .stall_i        (stall_i),
      .flush_i        (flush_i),
      .flush_pc_i     (flush_pc_i),
      .imem_data_i    (imem_data_i),
      .imem_req_o     (imem_req_o),
      .imem_addr_o    (imem_addr_o),
      .valid_o        (valid_o),
      .op_o           (op_o),
      .pc_o           (pc_o),
      .operand_o      (operand_o),
      .pcrel_offset_o (pcrel_offset_o),
      .reg_a_idx_o    (reg_a_idx_o),
      .reg_b_idx_o    (reg_b_idx_o),
      .control_o      (control_o)
   );

   always #5 clk_i = ~clk_i;

   // Request seen at the falling edge, data driven just after the next rising edge
   always @(negedge clk_i)
   begin
      req_seen  = imem_req_o;
      addr_seen = imem_addr_o;
   end

   always @(posedge clk_i)
   begin
      #1;
      if (req_seen)
         imem_data_i = prog[addr_seen[12:1]];
   end

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("mismatch at %0t: %s is %0h, expected %0h", $time, name, got, exp);
      end
   endtask

   // Outputs are consumed at the next rising edge
   always @(negedge clk_i)
   begin : compare_outputs
      fetch_entry_t rec;
      if (arst_n_i && valid_o && !stall_i && exp_q.size() > 0)
      begin
         rec = exp_q.pop_front();
         if (fresh)
         begin
            first_pc = pc_o;
            fresh    = 1'b0;
         end
         check_value("op_o", 32'(op_o), 32'(ref_op(rec.opcode)));
         check_value("pc_o", pc_o, rec.pc);
         check_value("operand_o", operand_o, ref_operand(rec));
         check_value("pcrel_offset_o", 32'(pcrel_offset_o), 32'(ref_offset(rec.opcode)));
         check_value("reg_a_idx_o", 32'(reg_a_idx_o), 32'(ref_reg_a(rec.opcode)));
         check_value("reg_b_idx_o", 32'(reg_b_idx_o), 32'(ref_reg_b(rec.opcode)));
         check_value("control_o", 32'(control_o), 32'(ref_control(rec.opcode)));
      end
   end

   function automatic logic [INSN_W-1:0] pick_opcode(input int kind);
      logic [7:0] hi;
      int         r;
      r = int'($urandom % 8);
      if (kind == KIND_INCDEC)
         hi = 8'h80 + 8'($urandom % 32);
      else if (kind == KIND_BRANCH)
         hi = 8'hC0 + 8'($urandom % 40);
      else if (r == 6)
         hi = 8'hC0 + 8'($urandom % 64);
      else if (r < 2)
      begin
         case ($urandom % 5)
            0:       hi = 8'h01;
            1:       hi = 8'h03;
            2:       hi = 8'h08;
            3:       hi = 8'h09;
            default: hi = 8'h1A;
         endcase
      end
      else if (r < 5)
      begin
         r  = int'($urandom % 48);
         hi = (r < 15) ? 8'(r) : 8'(r + 'h19 - 15);
      end
      else if (r == 5)
         hi = 8'h80 + 8'($urandom % 64);
      else
         hi = 8'h3A + 8'($urandom % 70);  // undefined form-1 codes
      return {hi, 8'($urandom)};
   endfunction

   // Writes the program image and the matching expected records
   task automatic gen_program(input logic [ADDR_W-1:0] base, input int count, input int kind);
      logic [ADDR_W-1:0] addr;
      fetch_entry_t      rec;
      logic [31:0]       imm;
      int                i;
      addr = base;
      for (i = 0; i < count; i++)
      begin
         rec.pc      = addr;
         rec.opcode  = pick_opcode(kind);
         rec.operand = '0;
         prog[addr[12:1]] = rec.opcode;
         if (ref_is_long(rec.opcode[15:8]))
         begin
            imm         = $urandom;
            rec.operand = imm;
            prog[12'(addr[12:1] + 1)] = imm[31:16];
            prog[12'(addr[12:1] + 2)] = imm[15:0];
            addr = addr + 6;
         end
         else
            addr = addr + 2;
         exp_q.push_back(rec);
      end
   endtask

   task automatic flush_to(input logic [ADDR_W-1:0] addr, input int count, input int kind);
      @(posedge clk_i);
      #1;
      stall_i    = 1'b0;
      flush_i    = 1'b1;
      flush_pc_i = addr;
      @(posedge clk_i);
      #1;
      flush_i = 1'b0;
      exp_q.delete();
      gen_program(addr, count, kind);
      fresh = 1'b1;
   endtask

   // Runs until no more than left records are still expected
   task automatic run_until(input int left, input bit random_stall);
      int cycles;
      int run_left;
      cycles   = 0;
      run_left = 0;
      while (exp_q.size() > left && cycles < DRAIN_LIMIT)
      begin
         @(posedge clk_i);
         #1;
         if (random_stall)
         begin
            if (run_left == 0)
            begin
               stall_i  = 1'($urandom % 2);
               run_left = 1 + int'($urandom % 6);
            end
            run_left--;
         end
         cycles++;
      end
      stall_i = 1'b0;
      if (exp_q.size() > left)
      begin
         errors++;
         $display("timeout: %0d expected outputs never arrived", exp_q.size() - left);
      end
   endtask

   task automatic wait_request();
      int cycles;
      cycles = 0;
      while (!imem_req_o && cycles < REQ_LIMIT)
      begin
         @(negedge clk_i);
         cycles++;
      end
      if (imem_req_o)
         check_value("imem_addr_o", imem_addr_o, RESET_PC);
      else
      begin
         errors++;
         $display("timeout: no memory request after reset");
      end
   endtask

   task automatic wait_fetch_idle();
      int cycles;
      @(posedge clk_i);
      #1;
      stall_i = 1'b1;
      cycles  = 0;
      while (imem_req_o && cycles < IDLE_LIMIT)
      begin
         @(negedge clk_i);
         cycles++;
      end
      if (imem_req_o)
      begin
         errors++;
         $display("timeout: fetch kept requesting during a long stall");
      end
      @(posedge clk_i);
      #1;
      stall_i = 1'b0;
   endtask

   task automatic report_test(input int num, input string name, input int err_before);
      tests_done++;
      $display("test %0d %s: %0d errors", num, name, errors - err_before);
   endtask

   initial
   begin : test_sequence
      int                i;
      int                seed_ret;
      int                err_before;
      logic [ADDR_W-1:0] jump_pc;
      seed_ret    = $urandom(32'ha5b9);
      clk_i       = 1'b0;
      arst_n_i    = 1'b0;
      stall_i     = 1'b0;
      flush_i     = 1'b0;
      flush_pc_i  = '0;
      imem_data_i = '0;
      req_seen    = 1'b0;
      addr_seen   = '0;
      fresh       = 1'b0;
      first_pc    = '0;
      checks      = 0;
      errors      = 0;
      tests_done  = 0;
      for (i = 0; i < MEM_HW; i++)
         prog[12'(i)] = 16'(i * 40503) ^ 16'h3c5a;
      gen_program(RESET_PC, 40, KIND_MIX);
      repeat (5) @(posedge clk_i);
      #1;
      arst_n_i = 1'b1;
      #1;

      err_before = errors;
      check_value("valid_o", 32'(valid_o), 32'd0);
      check_value("imem_req_o", 32'(imem_req_o), 32'd0);
      check_value("op_o", 32'(op_o), 32'(OP_NOP));
      wait_request();
      report_test(1, "reset state and first request", err_before);

      err_before = errors;
      run_until(0, 1'b0);
      report_test(2, "straight mixed program", err_before);

      err_before = errors;
      flush_to(32'h0000_0400, 24, KIND_INCDEC);
      run_until(0, 1'b0);
      report_test(3, "INC and DEC operands", err_before);

      err_before = errors;
      flush_to(32'h0000_0800, 24, KIND_BRANCH);
      run_until(0, 1'b0);
      report_test(4, "branch offsets", err_before);

      err_before = errors;
      flush_to(32'h0000_0C00, 60, KIND_MIX);
      run_until(30, 1'b1);
      wait_fetch_idle();
      run_until(0, 1'b1);
      report_test(5, "random stalls", err_before);

      err_before = errors;
      flush_to(32'h0000_1000, 30, KIND_MIX);
      run_until(18, 1'b1);
      jump_pc = 32'h0000_1400 + 32'(($urandom % 512) * 2);
      flush_to(jump_pc, 30, KIND_MIX);
      run_until(0, 1'b1);
      check_value("first pc after flush", first_pc, jump_pc);
      report_test(6, "flush redirect", err_before);

      $display("tests %0d, checks %0d, errors %0d", tests_done, checks, errors);
      if (errors == 0)
         $display("Test passed");
      else
         $display("Test failed");
      $finish;
   end

endmodule

/* cpu_frontend.f */
+incdir+test
common/cpu_fe_pkg.sv
fetch/insn_fetch.sv
rtl/insn_queue.sv
decode/microcode_rom.sv
decode/insn_decode.sv
rtl/cpu_frontend.sv
test/tb_cpu_frontend.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_cpu_frontend
RTL_TOP   ?= cpu_frontend
FILELIST  ?= cpu_frontend.f
BUILD_DIR ?= build
LOG       ?= $(BUILD_DIR)/sim.log
JOBS      ?= 0
VFLAGS    ?= --timing

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -j $(JOBS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR)
	$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -qx "Test passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR)
